//--- include/eth_frame_logger_defines.svh
`ifndef ETH_FRAME_LOGGER_DEFINES_SVH
`define ETH_FRAME_LOGGER_DEFINES_SVH

// beat width of the payload and log streams
`define LOG_WIDTH 64

// header constants
`define LOG_MAGIC        32'h02425AFF
`define LOG_DIRECTION_ID 8'd65
`define LOG_HEADER_BEATS 3

// three beats of 8 bytes minus the 8 byte preamble word
`define LOG_HEADER_BYTES 16

// buffer sizes
`define CTL_FIFO_DEPTH   4
`define FRAME_FIFO_DEPTH 16

`endif

//--- src/frame_ctl_pkg.sv
`include "eth_frame_logger_defines.svh"

package frame_ctl_pkg;

	// descriptor sent by the matcher for every frame
	typedef struct packed {
		logic [7:0]  flags;     // one bit per match rule
		logic [15:0] size;      // frame length in bytes
		logic [31:0] number;    // running frame number
		logic [63:0] timestamp; // capture time
	} frame_ctl_t;

	// one payload beat
	typedef logic [`LOG_WIDTH-1:0] frame_beat_t;

endpackage

//--- src/log_format_pkg.sv
package log_format_pkg;

	// log header, lowest word goes out first
	typedef struct packed {
		logic [7:0]  flags;     // copied from the descriptor
		logic [7:0]  log_width; // beat width in bytes
		logic [7:0]  direction;
		logic [31:0] number;
		logic [63:0] timestamp;
		logic [15:0] length;    // header bytes plus frame size
		logic [15:0] log_id;
		logic [31:0] magic;
	} log_header_t;

	// logger sequence
	typedef enum logic [1:0] {
		WAIT_CTL,   // idle, waiting for a descriptor
		TX_HEADER,  // sending header beats
		TX_FRAME,   // forwarding payload
		DROP_FRAME  // discarding payload of an unmatched frame
	} log_state_t;

endpackage

//--- src/log_fifo.sv
`timescale 1ns/1ps

module log_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n,

	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,

	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_pop
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_pop && out_valid;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

//--- src/log_beat_counter.sv
`timescale 1ns/1ps

`include "eth_frame_logger_defines.svh"

module log_beat_counter (
	input  logic        clk,
	input  logic        rst_n,

	input  logic        count_start,
	input  logic [15:0] start_size,

	input  logic        header_step,
	input  logic        frame_step,

	output logic        header_last,
	output logic        frame_last,
	output logic        size_zero
);
	localparam int IDX_W = $clog2(`LOG_HEADER_BEATS);
	localparam logic [15:0] BEAT_BYTES = 16'(`LOG_WIDTH / 8);

	logic [IDX_W-1:0] header_idx;
	logic [15:0] bytes_left;
	logic zero_size;

	assign header_last = (header_idx == IDX_W'(`LOG_HEADER_BEATS - 1));
	assign frame_last = (bytes_left <= BEAT_BYTES); // short last beat counts as full
	assign size_zero = zero_size;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			header_idx <= '0;
			bytes_left <= '0;
			zero_size <= 1'b0;
		end else if (count_start) begin
			header_idx <= '0;
			bytes_left <= start_size;
			zero_size <= (start_size == '0);
		end else begin
			if (header_step && !header_last) begin
				header_idx <= header_idx + 1'b1;
			end
			if (frame_step) begin
				bytes_left <= bytes_left - BEAT_BYTES;
			end
		end
	end

endmodule

//--- src/log_header_shifter.sv
`timescale 1ns/1ps

`include "eth_frame_logger_defines.svh"

module log_header_shifter
	import frame_ctl_pkg::*, log_format_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic [15:0]           log_id,

	input  logic                  header_load,
	input  frame_ctl_t            ctl,
	input  logic                  shift,

	output logic [`LOG_WIDTH-1:0] beat
);
	localparam int HDR_W = $bits(log_header_t);

	log_header_t hdr;

	assign beat = hdr[`LOG_WIDTH-1:0]; // low word leaves first

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hdr <= '0;
		end else if (header_load) begin
			hdr.flags <= ctl.flags;
			hdr.log_width <= 8'(`LOG_WIDTH / 8);
			hdr.direction <= `LOG_DIRECTION_ID;
			hdr.number <= ctl.number;
			hdr.timestamp <= ctl.timestamp;
			hdr.length <= ctl.size + 16'(`LOG_HEADER_BYTES);
			hdr.log_id <= log_id;
			hdr.magic <= `LOG_MAGIC;
		end else if (shift) begin
			// next word down, zeros in from the top
			hdr <= log_header_t'({{`LOG_WIDTH{1'b0}}, hdr[HDR_W-1:`LOG_WIDTH]});
		end
	end

endmodule

//--- src/log_fsm.sv
`timescale 1ns/1ps

module log_fsm
	import frame_ctl_pkg::*, log_format_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  frame_ctl_t ctl,
	input  logic       ctl_valid,
	output logic       ctl_pop,

	input  logic       header_last,
	input  logic       frame_last,
	input  logic       size_zero,

	input  logic       out_ready,
	input  logic       frame_valid,

	output log_state_t state,

	output logic       header_load,
	output logic       count_start,
	output logic       header_step,
	output logic       frame_step,

	output logic       out_valid,
	output logic       out_last,
	output logic       frame_pop
);
	log_state_t state_next;

	assign ctl_pop = (state == WAIT_CTL) && ctl_valid;
	assign header_load = ctl_pop; // shifter and counter load on the pop edge
	assign count_start = ctl_pop;

	assign header_step = (state == TX_HEADER) && out_ready;
	assign frame_step = ((state == TX_FRAME) && frame_valid && out_ready) ||
		((state == DROP_FRAME) && frame_valid); // drops ignore the output side
	assign frame_pop = frame_step;

	assign out_valid = (state == TX_HEADER) || ((state == TX_FRAME) && frame_valid);
	assign out_last = ((state == TX_HEADER) && header_last && size_zero) ||
		((state == TX_FRAME) && frame_valid && frame_last);

	always_comb begin
		state_next = state;
		case (state)
			WAIT_CTL: begin
				if (ctl_valid) begin
					if (ctl.flags != '0) begin
						state_next = TX_HEADER;
					end else if (ctl.size != '0) begin
						state_next = DROP_FRAME;
					end // empty unmatched descriptor just goes away
				end
			end
			TX_HEADER: begin
				if (header_step && header_last) begin
					state_next = size_zero ? WAIT_CTL : TX_FRAME;
				end
			end
			TX_FRAME, DROP_FRAME: begin
				if (frame_step && frame_last) begin
					state_next = WAIT_CTL;
				end
			end
			default: state_next = WAIT_CTL;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WAIT_CTL;
		end else begin
			state <= state_next;
		end
	end

endmodule

//--- src/eth_frame_logger.sv
`timescale 1ns/1ps

`include "eth_frame_logger_defines.svh"

module eth_frame_logger
	import frame_ctl_pkg::*, log_format_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic [15:0]           log_id,

	input  frame_ctl_t            s_ctl_tdata,
	input  logic                  s_ctl_tvalid,
	output logic                  s_ctl_tready,

	input  frame_beat_t           s_frame_tdata,
	input  logic                  s_frame_tvalid,
	output logic                  s_frame_tready,

	output logic [`LOG_WIDTH-1:0] m_log_tdata,
	output logic                  m_log_tlast,
	output logic                  m_log_tvalid,
	input  logic                  m_log_tready
);
	frame_ctl_t ctl;
	frame_beat_t frame_data;
	log_state_t state;
	logic [`LOG_WIDTH-1:0] header_beat;
	logic ctl_valid, ctl_pop;
	logic frame_valid, frame_pop;
	logic header_load, count_start, header_step, frame_step;
	logic header_last, frame_last, size_zero;

	log_fifo #(.payload_t(frame_ctl_t), .DEPTH(`CTL_FIFO_DEPTH)) ctl_fifo (
		.clk(clk), .rst_n(rst_n),
		.in_data(s_ctl_tdata), .in_valid(s_ctl_tvalid), .in_ready(s_ctl_tready),
		.out_data(ctl), .out_valid(ctl_valid), .out_pop(ctl_pop)
	);

	log_fifo #(.payload_t(frame_beat_t), .DEPTH(`FRAME_FIFO_DEPTH)) frame_fifo (
		.clk(clk), .rst_n(rst_n),
		.in_data(s_frame_tdata), .in_valid(s_frame_tvalid), .in_ready(s_frame_tready),
		.out_data(frame_data), .out_valid(frame_valid), .out_pop(frame_pop)
	);

	log_fsm fsm_i (
		.clk(clk), .rst_n(rst_n),
		.ctl(ctl), .ctl_valid(ctl_valid), .ctl_pop(ctl_pop),
		.header_last(header_last), .frame_last(frame_last), .size_zero(size_zero),
		.out_ready(m_log_tready), .frame_valid(frame_valid), .state(state),
		.header_load(header_load), .count_start(count_start),
		.header_step(header_step), .frame_step(frame_step),
		.out_valid(m_log_tvalid), .out_last(m_log_tlast), .frame_pop(frame_pop)
	);

	log_beat_counter counter_i (
		.clk(clk), .rst_n(rst_n),
		.count_start(count_start), .start_size(ctl.size),
		.header_step(header_step), .frame_step(frame_step),
		.header_last(header_last), .frame_last(frame_last), .size_zero(size_zero)
	);

	log_header_shifter shifter_i (
		.clk(clk), .rst_n(rst_n), .log_id(log_id),
		.header_load(header_load), .ctl(ctl), .shift(header_step),
		.beat(header_beat)
	);

	// output data source follows the phase
	always_comb begin
		case (state)
			TX_HEADER: m_log_tdata = header_beat;
			TX_FRAME:  m_log_tdata = frame_data;
			default:   m_log_tdata = '0;
		endcase
	end

endmodule

//--- test/eth_frame_logger_props.sv
`timescale 1ns/1ps

`include "eth_frame_logger_defines.svh"

module eth_frame_logger_props (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`LOG_WIDTH-1:0] m_log_tdata,
	input  logic                  m_log_tlast,
	input  logic                  m_log_tvalid,
	input  logic                  m_log_tready
);
	int fail_count = 0; // failed checks so far

	// a stalled beat holds until the sink takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		m_log_tvalid && !m_log_tready |=> m_log_tvalid && $stable(m_log_tdata))
	else begin
		fail_count++;
		$error("m_log beat dropped or changed while stalled");
	end

	assert property (@(posedge clk) disable iff (!rst_n) m_log_tlast |-> m_log_tvalid)
	else begin
		fail_count++;
		$error("m_log_tlast high without m_log_tvalid");
	end

	assert property (@(posedge clk) !rst_n |=> !m_log_tvalid) // idle out of reset
	else begin
		fail_count++;
		$error("m_log_tvalid high in the cycle after reset");
	end

endmodule

bind eth_frame_logger eth_frame_logger_props props_i (
	.clk(clk), .rst_n(rst_n), .m_log_tdata(m_log_tdata),
	.m_log_tlast(m_log_tlast), .m_log_tvalid(m_log_tvalid), .m_log_tready(m_log_tready)
);

//--- test/tb_eth_frame_logger.sv
`timescale 1ns/1ps

`include "eth_frame_logger_defines.svh"

module tb_eth_frame_logger
	import frame_ctl_pkg::*;
();
	localparam int HALF_PERIOD = 20;
	localparam int MAX_RECORDS = 64;
	localparam int WAIT_LIMIT = 200; // cycles per handshake
	localparam logic [15:0] TB_LOG_ID = 16'h1a2b;

	logic clk;
	logic rst_n;
	logic [15:0] log_id;
	frame_ctl_t s_ctl_tdata;
	logic s_ctl_tvalid;
	logic s_ctl_tready;
	frame_beat_t s_frame_tdata;
	logic s_frame_tvalid;
	logic s_frame_tready;
	logic [`LOG_WIDTH-1:0] m_log_tdata;
	logic m_log_tlast;
	logic m_log_tvalid;
	logic m_log_tready;

	logic [127:0] records [MAX_RECORDS];
	frame_ctl_t ctl_q[$];
	frame_beat_t beat_q[$];
	logic [`LOG_WIDTH:0] exp_q[$]; // tlast above the data
	int errors;

	eth_frame_logger eth_frame_logger_i (.*);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	always @(negedge clk) begin
		if (eth_frame_logger_i.props_i.fail_count != 0)
			abort_run("a protocol assertion on the log stream failed");
	end

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic toggle_ready();
		forever begin
			@(posedge clk);
			m_log_tready <= ($urandom % 3) != 0; // stall about one cycle in three
		end
	endtask

	task automatic load_records();
		logic [127:0] rec;
		int idx;
		bit more;
		$readmemh("test/logger_input.txt", records);
		idx = 0;
		more = 1'b1;
		while (more && idx < MAX_RECORDS) begin
			rec = records[idx];
			case (rec[127:124]) // record kind in the top digit
				4'hc: ctl_q.push_back(rec[119:0]);
				4'hf: beat_q.push_back(rec[63:0]);
				4'he: exp_q.push_back({|rec[67:64], rec[63:0]});
				default: more = 1'b0;
			endcase
			idx++;
		end
		if (exp_q.size() == 0) abort_run("data file holds no expected output beats");
	endtask

	task automatic drive_ctl();
		int waited;
		foreach (ctl_q[i]) begin
			s_ctl_tdata <= ctl_q[i];
			s_ctl_tvalid <= 1'b1;
			waited = 0;
			@(negedge clk);
			while (!s_ctl_tready) begin
				waited++;
				if (waited > WAIT_LIMIT) abort_run("timeout: descriptor was never accepted");
				@(negedge clk);
			end
			@(posedge clk); // transfer edge
		end
		s_ctl_tvalid <= 1'b0;
	endtask

	task automatic drive_frames();
		int waited;
		int gap;
		foreach (beat_q[i]) begin
			gap = $urandom % 6; // idle cycles before this beat
			if (gap != 0) begin
				s_frame_tvalid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			s_frame_tdata <= beat_q[i];
			s_frame_tvalid <= 1'b1;
			waited = 0;
			@(negedge clk);
			while (!s_frame_tready) begin
				waited++;
				if (waited > WAIT_LIMIT) abort_run("timeout: payload beat was never accepted");
				@(negedge clk);
			end
			@(posedge clk);
		end
		s_frame_tvalid <= 1'b0;
	endtask

	task automatic check_output();
		logic [`LOG_WIDTH:0] want;
		int waited;
		foreach (exp_q[i]) begin
			want = exp_q[i];
			waited = 0;
			@(negedge clk);
			while (!(m_log_tvalid && m_log_tready)) begin
				waited++;
				if (waited > WAIT_LIMIT)
					abort_run($sformatf("timeout: log beat %0d never arrived", i));
				@(negedge clk);
			end
			assert (m_log_tdata == want[`LOG_WIDTH-1:0]) else
				abort_run($sformatf("MISMATCH at %0t: m_log_tdata got %h, expected %h",
					$time, m_log_tdata, want[`LOG_WIDTH-1:0]));
			assert (m_log_tlast == want[`LOG_WIDTH]) else
				abort_run($sformatf("MISMATCH at %0t: m_log_tlast got %b, expected %b",
					$time, m_log_tlast, want[`LOG_WIDTH]));
		end
	endtask

	initial begin
		errors = 0;
		void'($urandom(32'h91a1_d765));
		rst_n = 1'b0;
		log_id = TB_LOG_ID;
		s_ctl_tdata = '0;
		s_ctl_tvalid = 1'b0;
		s_frame_tdata = '0;
		s_frame_tvalid = 1'b0;
		m_log_tready = 1'b0;
		load_records();
		fork
			toggle_ready();
		join_none
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		fork
			drive_ctl();
			drive_frames();
			check_output();
		join
		repeat (20) begin // nothing may follow the last packet
			@(negedge clk);
			assert (!m_log_tvalid) else abort_run("log stream sent a beat after the last packet");
		end
		if (errors == 0 && eth_frame_logger_i.props_i.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- eth_frame_logger.f
+incdir+include
src/frame_ctl_pkg.sv
src/log_format_pkg.sv
src/log_fifo.sv
src/log_beat_counter.sv
src/log_header_shifter.sv
src/log_fsm.sv
src/eth_frame_logger.sv
test/eth_frame_logger_props.sv
test/tb_eth_frame_logger.sv

//--- Bender.yml
package:
  name: eth_frame_logger

sources:
  - include_dirs:
      - include
    files:
      - src/frame_ctl_pkg.sv
      - src/log_format_pkg.sv
      - src/log_fifo.sv
      - src/log_beat_counter.sv
      - src/log_header_shifter.sv
      - src/log_fsm.sv
      - src/eth_frame_logger.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/eth_frame_logger_props.sv
      - test/tb_eth_frame_logger.sv

//--- test/logger_input.txt
// C: tag, pad, flags, size, number, timestamp   F: tag, zeros, payload beat
// E: tag, zeros, tlast digit, expected log beat (log_id 1a2b in the header)
C0_05_0010_00000001_00000012_3456789a
F0000000_00000000_11112222_33334444
F0000000_00000000_55556666_77778888
E0000000_00000000_00201a2b_02425aff
E0000000_00000000_00000012_3456789a
E0000000_00000000_00050841_00000001
E0000000_00000000_11112222_33334444
E0000000_00000001_55556666_77778888
C0_80_0000_00000002_00000000_00001000
E0000000_00000000_00101a2b_02425aff
E0000000_00000000_00000000_00001000
E0000000_00000001_00800841_00000002
C0_00_0014_00000003_00000000_00002000
F0000000_00000000_deaddead_00000001
F0000000_00000000_deaddead_00000002
F0000000_00000000_deaddead_00000003
C0_12_000c_00000004_000000ab_cdef0001
F0000000_00000000_a0a1a2a3_a4a5a6a7
F0000000_00000000_b0b1b2b3_00000000
E0000000_00000000_001c1a2b_02425aff
E0000000_00000000_000000ab_cdef0001
E0000000_00000000_00120841_00000004
E0000000_00000000_a0a1a2a3_a4a5a6a7
E0000000_00000001_b0b1b2b3_00000000
C0_00_0000_00000005_00000000_00003000
C0_ff_0008_00000006_00000000_00004000
F0000000_00000000_cafef00d_12345678
E0000000_00000000_00181a2b_02425aff
E0000000_00000000_00000000_00004000
E0000000_00000000_00ff0841_00000006
E0000000_00000001_cafef00d_12345678
